// ==== flist.f ====
src/mips_isa_pkg.sv
src/lsu_pkg.sv
src/lsu_op_decode.sv
src/lsu_access.sv
src/load_align.sv
src/lsu_top.sv
verif/tb_data_sram.sv
verif/tb_lsu.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_lsu
FLIST     := flist.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu;

    localparam int N_REQ      = 3000;
    localparam int WAIT_LIMIT = 200;

    typedef struct {
        lsu_pkg::lsu_wb_t wb;
        logic             chk_data;    // data is only defined for legal loads
        string            name;
    } exp_item_t;

    logic                 clk;
    logic                 rst_n;
    lsu_pkg::lsu_req_t    req;
    logic                 req_valid;
    logic                 req_ready;
    lsu_pkg::lsu_wb_t     wb;
    logic                 wb_valid;
    logic                 wb_ready;
    logic                 sram_en;
    lsu_pkg::byte_en_t    sram_wen;
    mips_isa_pkg::paddr_t sram_addr;
    mips_isa_pkg::word_t  sram_wdata;
    mips_isa_pkg::word_t  sram_rdata;

    integer               seed;
    mips_isa_pkg::word_t  shadow [256];
    exp_item_t            exp_q [$];
    int                   n_data, n_be, n_dest, n_err, n_addr, n_proto;
    logic                 timed_out;
    logic                 last_accept;
    logic                 last_stall;

    lsu_top UUT (.clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid),
                 .req_ready(req_ready), .wb(wb), .wb_valid(wb_valid), .wb_ready(wb_ready),
                 .sram_en(sram_en), .sram_wen(sram_wen), .sram_addr(sram_addr),
                 .sram_wdata(sram_wdata), .sram_rdata(sram_rdata));

    tb_data_sram u_sram (.clk(clk), .en(sram_en), .wen(sram_wen), .addr(sram_addr),
                         .wdata(sram_wdata), .rdata(sram_rdata));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_data(input string name, input mips_isa_pkg::word_t exp,
                              input mips_isa_pkg::word_t act);
        if (exp !== act) begin
            $display("Error: %s data expected %h actual %h", name, exp, act);
            n_data++;
        end
    endtask

    task automatic check_be(input string name, input lsu_pkg::byte_en_t exp,
                            input lsu_pkg::byte_en_t act);
        if (exp !== act) begin
            $display("Error: %s reg_be expected %b actual %b", name, exp, act);
            n_be++;
        end
    endtask

    task automatic check_dest(input string name, input mips_isa_pkg::reg_idx_t exp,
                              input mips_isa_pkg::reg_idx_t act);
        if (exp !== act) begin
            $display("Error: %s dest expected %0d actual %0d", name, exp, act);
            n_dest++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error: %s addr_err expected %b actual %b", name, exp, act);
            n_err++;
        end
    endtask

    task automatic check_addr(input string name, input mips_isa_pkg::paddr_t exp,
                              input mips_isa_pkg::paddr_t act);
        if (exp !== act) begin
            $display("Error: %s sram_addr expected %h actual %h", name, exp, act);
            n_addr++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            n_proto++;
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic int rand_range(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic mips_isa_pkg::paddr_t map_addr(input mips_isa_pkg::vaddr_t va);
        mips_isa_pkg::paddr_t pa;
        pa = va;
        if (va[31:30] == 2'b10) pa[31:29] = 3'b000;   // kseg0 and kseg1
        return pa;
    endfunction

    function automatic logic is_misaligned(input mips_isa_pkg::mem_op_t op,
                                           input logic [1:0] b);
        case (op)
            mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LHU, mips_isa_pkg::OP_SH: return b[0];
            mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW: return b != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    function automatic lsu_pkg::lsu_wb_t expect_wb(input lsu_pkg::lsu_req_t r,
                                                   input mips_isa_pkg::word_t w);
        lsu_pkg::lsu_wb_t e;
        logic [1:0]       b;
        logic [7:0]       by;
        logic [15:0]      hf;
        int               i;
        b          = r.vaddr[1:0];
        by         = 8'(w >> (8 * b));
        hf         = b[1] ? w[31:16] : w[15:0];
        e.data     = '0;
        e.reg_be   = 4'b1111;
        e.dest     = r.dest;
        e.addr_err = is_misaligned(r.op, b);
        case (r.op)
            mips_isa_pkg::OP_LB:  e.data = {{24{by[7]}}, by};
            mips_isa_pkg::OP_LBU: e.data = {24'h0, by};
            mips_isa_pkg::OP_LH:  e.data = {{16{hf[15]}}, hf};
            mips_isa_pkg::OP_LHU: e.data = {16'h0, hf};
            mips_isa_pkg::OP_LW:  e.data = w;
            mips_isa_pkg::OP_LWL: begin
                e.data = w << (8 * (3 - b));
                for (i = 0; i < 4; i++) e.reg_be[i] = (i >= 3 - b);   // top b+1 bytes
            end
            mips_isa_pkg::OP_LWR: begin
                e.data = w >> (8 * b);
                for (i = 0; i < 4; i++) e.reg_be[i] = (i < 4 - b);    // low 4-b bytes
            end
            default: e.reg_be = 4'b0000;                             // stores
        endcase
        if (e.addr_err || r.dest == 5'd0) e.reg_be = 4'b0000;
        return e;
    endfunction

    task automatic apply_store(input lsu_pkg::lsu_req_t r);
        mips_isa_pkg::paddr_t pa;
        logic [1:0]           b;
        pa = map_addr(r.vaddr);
        b  = r.vaddr[1:0];
        if (!is_misaligned(r.op, b)) begin
            case (r.op)
                mips_isa_pkg::OP_SB: shadow[pa[9:2]][8*b +: 8] = r.store_data[7:0];
                mips_isa_pkg::OP_SH: shadow[pa[9:2]][16*b[1] +: 16] = r.store_data[15:0];
                mips_isa_pkg::OP_SW: shadow[pa[9:2]] = r.store_data;
                default: ;
            endcase
        end
    endtask

    function automatic lsu_pkg::lsu_req_t random_req();
        lsu_pkg::lsu_req_t r;
        logic [31:0]       base;
        logic [9:0]        low;
        case (rand_range(3))
            0: base = 32'h0000_0000;
            1: base = 32'h8000_0000;
            default: base = 32'hA000_0000;
        endcase
        // half the traffic hits 8 hot words so loads see earlier stores
        low          = (rand_range(2) == 0) ? 10'(rand_range(1024)) : 10'(rand_range(32));
        r.vaddr      = base | {22'h0, low};
        r.op         = mips_isa_pkg::mem_op_t'(4'(rand_range(10)));
        r.store_data = $random(seed);
        r.dest       = (rand_range(8) == 0) ? 5'd0 : 5'(rand_range(32));
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // per-cycle drive and observe
    // ------------------------------------------------------------------------

    task automatic next_cycle();
        @(negedge clk);
        wb_ready = (rand_range(4) != 0);   // stall about a quarter of the time
    endtask

    task automatic observe(output logic accepted);
        exp_item_t            it;
        mips_isa_pkg::mem_op_t op;
        mips_isa_pkg::paddr_t pa;
        #1;
        check_bit("req_ready", (exp_q.size() == 0) || wb_ready, req_ready);
        if (last_stall) begin
            check_bit("wb_valid held in stall", 1'b1, wb_valid);
            if (exp_q.size() != 0) begin
                it = exp_q[0];       // item still parked in the stage
                if (it.chk_data) check_data({it.name, " stalled"}, it.wb.data, wb.data);
                check_be({it.name, " stalled"}, it.wb.reg_be, wb.reg_be);
                check_dest({it.name, " stalled"}, it.wb.dest, wb.dest);
            end
        end
        if (last_accept) check_bit("wb_valid one cycle after accept", 1'b1, wb_valid);
        if (wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("writeback item appeared with no request pending");
                n_proto++;
            end else begin
                it = exp_q.pop_front();
                if (it.chk_data) check_data(it.name, it.wb.data, wb.data);
                check_be(it.name, it.wb.reg_be, wb.reg_be);
                check_dest(it.name, it.wb.dest, wb.dest);
                check_err(it.name, it.wb.addr_err, wb.addr_err);
            end
        end
        last_stall = wb_valid && !wb_ready;
        accepted   = req_valid && req_ready;
        op         = req.op;
        check_bit("sram_en", accepted && !is_misaligned(op, req.vaddr[1:0]), sram_en);
        if (accepted) begin
            pa          = map_addr(req.vaddr);
            it.name     = $sformatf("%s @%h", op.name(), req.vaddr);
            it.wb       = expect_wb(req, shadow[pa[9:2]]);
            it.chk_data = (op <= mips_isa_pkg::OP_LWR) && !it.wb.addr_err;
            if (sram_en) check_addr(it.name, pa, sram_addr);
            exp_q.push_back(it);
            apply_store(req);
        end
        last_accept = accepted;
    endtask

    task automatic issue(input lsu_pkg::lsu_req_t r);
        logic acc;
        int   waited;
        next_cycle();
        req       = r;
        req_valid = 1'b1;
        observe(acc);
        waited = 0;
        while (!acc && waited < WAIT_LIMIT) begin
            next_cycle();
            observe(acc);
            waited++;
        end
        if (!acc) begin
            $display("timeout: req_ready stayed low and the request was never accepted");
            n_proto++;
            timed_out = 1'b1;
        end
    endtask

    task automatic idle_cycle();
        logic acc;
        next_cycle();
        req_valid = 1'b0;
        observe(acc);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: wb_valid never delivered %0d pending items", exp_q.size());
            n_proto++;
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed        = 32'h2b35;
        rst_n       = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        wb_ready    = 1'b1;
        {n_data, n_be, n_dest, n_err, n_addr, n_proto} = '0;
        timed_out   = 1'b0;
        last_accept = 1'b0;
        last_stall  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = {8'(i), 8'(i) ^ 8'hA5, ~8'(i), 8'(i) + 8'h3C};
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit("req_ready after reset", 1'b1, req_ready);
        check_bit("wb_valid after reset", 1'b0, wb_valid);
        check_bit("sram_en after reset", 1'b0, sram_en);
        for (int n = 0; n < N_REQ && !timed_out; n++) begin
            if (rand_range(8) == 0) idle_cycle();
            issue(random_req());
        end
        if (!timed_out) drain();
        $display("errors: data %0d, be %0d, dest %0d, err %0d, addr %0d, protocol %0d",
                 n_data, n_be, n_dest, n_err, n_addr, n_proto);
        if (n_data + n_be + n_dest + n_err + n_addr + n_proto == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/tb_data_sram.sv ====
`timescale 1ns/1ps

module tb_data_sram (
    input  logic                 clk,
    input  logic                 en,
    input  lsu_pkg::byte_en_t    wen,
    input  mips_isa_pkg::paddr_t addr,
    input  mips_isa_pkg::word_t  wdata,
    output mips_isa_pkg::word_t  rdata
);

    mips_isa_pkg::word_t mem [256];
    logic [7:0]          idx;

    assign idx = addr[9:2];              // 1 KB, word addressed

    // every byte of the fill depends on the full word index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), 8'(i) ^ 8'hA5, ~8'(i), 8'(i) + 8'h3C};
        end
        rdata = '0;
    end

    always @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];           // read first, old word on a write
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // request from execute
    input  lsu_pkg::lsu_req_t    req,
    input  logic                 req_valid,
    output logic                 req_ready,

    // writeback item
    output lsu_pkg::lsu_wb_t     wb,
    output logic                 wb_valid,
    input  logic                 wb_ready,

    // data sram
    output logic                 sram_en,
    output lsu_pkg::byte_en_t    sram_wen,
    output mips_isa_pkg::paddr_t sram_addr,
    output mips_isa_pkg::word_t  sram_wdata,
    input  mips_isa_pkg::word_t  sram_rdata
);

    lsu_pkg::lsu_ctrl_t ctrl;
    lsu_pkg::lsu_ctrl_t stage_ctrl;
    logic               stage_valid;
    logic               stage_fresh;

    lsu_op_decode u_decode (
        .req  (req),
        .ctrl (ctrl)
    );

    lsu_access u_access (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .vaddr       (req.vaddr),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .wb_ready    (wb_ready),
        .stage_valid (stage_valid),
        .stage_ctrl  (stage_ctrl),
        .stage_fresh (stage_fresh),
        .sram_en     (sram_en),
        .sram_wen    (sram_wen),
        .sram_addr   (sram_addr),
        .sram_wdata  (sram_wdata)
    );

    load_align u_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .stage_ctrl  (stage_ctrl),
        .stage_fresh (stage_fresh),
        .sram_rdata  (sram_rdata),
        .wb          (wb),
        .wb_valid    (wb_valid)
    );

endmodule

// ==== src/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                stage_valid,
    input  lsu_pkg::lsu_ctrl_t  stage_ctrl,
    input  logic                stage_fresh,

    input  mips_isa_pkg::word_t sram_rdata,

    output lsu_pkg::lsu_wb_t    wb,
    output logic                wb_valid
);

    mips_isa_pkg::word_t rdata_hold;
    mips_isa_pkg::word_t rdata;
    logic [1:0]          b;
    logic [7:0]          sel_byte;
    logic [15:0]         sel_half;
    mips_isa_pkg::word_t load_data;
    lsu_pkg::byte_en_t   load_be;
    logic                be_kill;

    // -------------------------------------------------------------------------
    // read data hold
    // -------------------------------------------------------------------------

    // sram output is only good for one cycle, so keep a copy for stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_hold <= '0;
        end else if (stage_fresh) begin
            rdata_hold <= sram_rdata;
        end
    end

    assign rdata = stage_fresh ? sram_rdata : rdata_hold;  // bypass on first cycle

    // -------------------------------------------------------------------------
    // extraction
    // -------------------------------------------------------------------------

    assign b        = stage_ctrl.byte_off;
    assign sel_byte = rdata[{b, 3'b000} +: 8];
    assign sel_half = b[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        load_data = rdata;
        load_be   = lsu_pkg::BE_ALL;
        case (stage_ctrl.op)
            mips_isa_pkg::OP_LB:  load_data = {{24{sel_byte[7]}}, sel_byte};
            mips_isa_pkg::OP_LBU: load_data = {24'b0, sel_byte};
            mips_isa_pkg::OP_LH:  load_data = {{16{sel_half[15]}}, sel_half};
            mips_isa_pkg::OP_LHU: load_data = {16'b0, sel_half};
            mips_isa_pkg::OP_LWL: begin
                // memory bytes b..0 land in the top of the register
                load_data = rdata << {~b, 3'b000};
                load_be   = lsu_pkg::byte_en_t'(4'b1111 << ~b);
            end
            mips_isa_pkg::OP_LWR: begin
                load_data = rdata >> {b, 3'b000};
                load_be   = lsu_pkg::byte_en_t'(4'b1111 >> b);  // low 4-b bytes
            end
            default: begin
                // lw and stores take the word as is
                load_data = rdata;
            end
        endcase
    end

    // -------------------------------------------------------------------------
    // writeback item
    // -------------------------------------------------------------------------

    // no register write for stores, bad addresses or r0
    assign be_kill = !stage_ctrl.is_load || stage_ctrl.addr_err ||
                     (stage_ctrl.dest == '0);

    always_comb begin
        wb.data     = stage_ctrl.is_load ? load_data : '0;
        wb.reg_be   = be_kill ? lsu_pkg::BE_NONE : load_be;
        wb.dest     = stage_ctrl.dest;
        wb.addr_err = stage_ctrl.addr_err;
    end

    assign wb_valid = stage_valid;

endmodule

// ==== src/lsu_access.sv ====
`timescale 1ns/1ps

module lsu_access (
    input  logic                 clk,
    input  logic                 rst_n,

    input  lsu_pkg::lsu_ctrl_t   ctrl,
    input  mips_isa_pkg::vaddr_t vaddr,
    input  logic                 req_valid,
    output logic                 req_ready,

    input  logic                 wb_ready,

    output logic                 stage_valid,
    output lsu_pkg::lsu_ctrl_t   stage_ctrl,
    output logic                 stage_fresh,

    output logic                 sram_en,
    output lsu_pkg::byte_en_t    sram_wen,
    output mips_isa_pkg::paddr_t sram_addr,
    output mips_isa_pkg::word_t  sram_wdata
);

    logic                 accept;
    logic                 in_kseg;
    mips_isa_pkg::paddr_t paddr;

    // -------------------------------------------------------------------------
    // handshake
    // -------------------------------------------------------------------------

    // stage frees up when its item leaves on this edge
    assign req_ready = !stage_valid || wb_ready;
    assign accept    = req_valid && req_ready;

    // -------------------------------------------------------------------------
    // one-entry stage register
    // -------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            stage_fresh <= 1'b0;
        end else begin
            if (accept) begin
                stage_valid <= 1'b1;
            end else if (wb_ready) begin
                stage_valid <= 1'b0;     // drained, nothing new
            end
            // read data shows up on sram_rdata right after the accept edge
            stage_fresh <= accept && ctrl.is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_ctrl <= ctrl;
        end
    end

    // -------------------------------------------------------------------------
    // fixed segment mapping
    // -------------------------------------------------------------------------

    assign in_kseg = (vaddr >= lsu_pkg::KSEG_LO) && (vaddr <= lsu_pkg::KSEG_HI);

    always_comb begin
        paddr = vaddr;                   // kuseg / kseg2+ pass through
        if (in_kseg) begin
            paddr[$bits(mips_isa_pkg::paddr_t)-1 -: lsu_pkg::SEG_MASK_BITS] = '0;
        end
    end

    // -------------------------------------------------------------------------
    // sram drive, issued in the accept cycle
    // -------------------------------------------------------------------------

    assign sram_en    = accept && !ctrl.addr_err;
    assign sram_wen   = sram_en ? ctrl.sram_wen : lsu_pkg::BE_NONE;
    assign sram_addr  = paddr;
    assign sram_wdata = ctrl.sram_wdata;  // already lane shaped

endmodule

// ==== src/lsu_op_decode.sv ====
`timescale 1ns/1ps

module lsu_op_decode (
    input  lsu_pkg::lsu_req_t  req,
    output lsu_pkg::lsu_ctrl_t ctrl
);

    logic [1:0]          off;
    mips_isa_pkg::word_t sd;
    lsu_pkg::byte_en_t   wen;
    mips_isa_pkg::word_t wdata;
    logic                is_load;
    logic                misaligned;

    assign off = req.vaddr[1:0];
    assign sd  = req.store_data;

    // -------------------------------------------------------------------------
    // op class, store lanes, alignment
    // -------------------------------------------------------------------------

    always_comb begin
        is_load    = 1'b0;
        misaligned = 1'b0;
        wen        = lsu_pkg::BE_NONE;
        wdata      = sd;
        case (req.op)
            mips_isa_pkg::OP_LB,
            mips_isa_pkg::OP_LBU: begin
                is_load = 1'b1;
            end
            mips_isa_pkg::OP_LH,
            mips_isa_pkg::OP_LHU: begin
                is_load    = 1'b1;
                misaligned = off[0];         // half needs even offset
            end
            mips_isa_pkg::OP_LW: begin
                is_load    = 1'b1;
                misaligned = |off;
            end
            mips_isa_pkg::OP_LWL,
            mips_isa_pkg::OP_LWR: begin
                is_load = 1'b1;              // any offset is legal
            end
            mips_isa_pkg::OP_SB: begin
                wen   = lsu_pkg::byte_en_t'(4'b0001 << off);
                wdata = {4{sd[7:0]}};        // byte on every lane
            end
            mips_isa_pkg::OP_SH: begin
                misaligned = off[0];
                wen        = off[1] ? 4'b1100 : 4'b0011;
                wdata      = {2{sd[15:0]}};
            end
            mips_isa_pkg::OP_SW: begin
                misaligned = |off;
                wen        = lsu_pkg::BE_ALL;
            end
            default: begin
                // unused encodings act as no-ops
                is_load = 1'b0;
            end
        endcase
    end

    // -------------------------------------------------------------------------
    // pack the control word
    // -------------------------------------------------------------------------

    always_comb begin
        ctrl.op         = req.op;
        ctrl.byte_off   = off;
        ctrl.is_load    = is_load;
        ctrl.addr_err   = misaligned;
        ctrl.dest       = req.dest;
        ctrl.sram_wdata = wdata;

        // a misaligned store must not touch memory
        ctrl.sram_wen = misaligned ? lsu_pkg::BE_NONE : wen;
    end

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    // -------------------------------------------------------------------------
    // byte lanes
    // -------------------------------------------------------------------------

    // bit i covers data bits 8i+7 .. 8i
    typedef logic [3:0] byte_en_t;

    localparam byte_en_t BE_NONE = 4'b0000;
    localparam byte_en_t BE_ALL  = 4'b1111;

    // -------------------------------------------------------------------------
    // fixed mapping window (kseg0 + kseg1)
    // -------------------------------------------------------------------------

    localparam mips_isa_pkg::vaddr_t KSEG_LO = 32'h8000_0000;
    localparam mips_isa_pkg::vaddr_t KSEG_HI = 32'hBFFF_FFFF;
    localparam int SEG_MASK_BITS = 3;  // top bits cleared inside the window

    // -------------------------------------------------------------------------
    // structs passed between the lsu blocks
    // -------------------------------------------------------------------------

    // request from execute
    typedef struct packed {
        mips_isa_pkg::mem_op_t  op;
        mips_isa_pkg::vaddr_t   vaddr;
        mips_isa_pkg::word_t    store_data;   // raw rt value
        mips_isa_pkg::reg_idx_t dest;
    } lsu_req_t;

    // decoded control, also the stage register payload
    typedef struct packed {
        mips_isa_pkg::mem_op_t  op;
        logic [1:0]             byte_off;     // vaddr[1:0]
        byte_en_t               sram_wen;     // zero for loads and errors
        mips_isa_pkg::word_t    sram_wdata;   // lane-replicated store data
        logic                   is_load;
        logic                   addr_err;
        mips_isa_pkg::reg_idx_t dest;
    } lsu_ctrl_t;

    // writeback item
    typedef struct packed {
        mips_isa_pkg::word_t    data;
        byte_en_t               reg_be;       // per-byte gpr write enable
        mips_isa_pkg::reg_idx_t dest;
        logic                   addr_err;
    } lsu_wb_t;

endpackage

// ==== src/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // -------------------------------------------------------------------------
    // architectural widths
    // -------------------------------------------------------------------------

    typedef logic [31:0] word_t;     // gpr / memory data word
    typedef logic [31:0] vaddr_t;    // address as computed by execute
    typedef logic [31:0] paddr_t;    // address after segment mapping
    typedef logic [4:0]  reg_idx_t;  // gpr number, r0 is hardwired zero

    // -------------------------------------------------------------------------
    // memory ops handled by the lsu
    // -------------------------------------------------------------------------

    // loads first, stores after, so op[3] is never set for a load
    typedef enum logic [3:0] {
        OP_LB  = 4'd0,   // byte, sign extended
        OP_LBU = 4'd1,   // byte, zero extended
        OP_LH  = 4'd2,   // half, sign extended
        OP_LHU = 4'd3,   // half, zero extended
        OP_LW  = 4'd4,   // full word
        OP_LWL = 4'd5,   // left part of an unaligned word
        OP_LWR = 4'd6,   // right part of an unaligned word
        OP_SB  = 4'd7,   // store byte
        OP_SH  = 4'd8,   // store half
        OP_SW  = 4'd9    // store word
    } mem_op_t;

endpackage
